// File: common/wed_defs.svh
`ifndef WED_DEFS_SVH
`define WED_DEFS_SVH

// Engine controllers sharing the read bridge
`define WED_ENGINES 4

// 32-bit words in one WED line
`define WED_WORDS 4

`define WB_DATA_W 32
`define WB_ADDR_W 32

// Tag carries the engine index
`define WED_TAG_W ((`WED_ENGINES > 1) ? $clog2(`WED_ENGINES) : 1)

// Selects a word inside a line
`define WED_INDEX_W ((`WED_WORDS > 1) ? $clog2(`WED_WORDS) : 1)

`endif

// File: common/wed_pkg.sv
`include "wed_defs.svh"

package wed_pkg;

  // Per-engine fetch controller
  typedef enum logic [2:0] {
    WED_RESET,
    WED_IDLE,
    WED_REQ,
    WED_WAITING,
    WED_DONE,
    WED_FAULTED
  } wed_state;

  // Host read bridge sequencing
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_CYCLE,   // Wishbone word cycle in progress
    BR_BEAT,    // Word handed to the controllers
    BR_RESPOND  // Completion for the whole line
  } bridge_state;

  typedef enum logic {
    RESP_DONE,
    RESP_FAULT
  } response_code;

  // Decoded work element descriptor
  typedef struct packed {
    logic [31:0] source_address;
    logic [31:0] dest_address;
    logic [31:0] length;
    logic [31:0] flags;
  } wed_t;

  // Word 0 sits in the low bits of the captured line
  function automatic wed_t map_to_wed(input logic [`WED_WORDS*`WB_DATA_W-1:0] line);
    wed_t w;
    w.source_address = line[31:0];
    w.dest_address   = line[63:32];
    w.length         = line[95:64];
    w.flags          = line[127:96];
    return w;
  endfunction

endpackage

// File: wed_control/wed_control.sv
`timescale 1ns/100ps
`include "wed_defs.svh"

module wed_control #(
  parameter int ENGINE_ID = 0
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    enabled,
  input  logic [`WB_ADDR_W-1:0]   wed_address,
  output logic                    cmd_req,
  output logic [`WB_ADDR_W-1:0]   cmd_address,
  input  logic                    cmd_accept,
  input  logic                    beat_valid,
  input  logic [`WED_TAG_W-1:0]   beat_tag,
  input  logic [`WED_INDEX_W-1:0] beat_index,
  input  logic [`WB_DATA_W-1:0]   beat_data,
  input  logic                    resp_valid,
  input  logic [`WED_TAG_W-1:0]   resp_tag,
  input  wed_pkg::response_code   resp_code,
  output wed_pkg::wed_t           wed,
  output logic                    wed_valid,
  output logic                    wed_fault
);

  localparam logic [`WED_TAG_W-1:0] MY_TAG = ENGINE_ID[`WED_TAG_W-1:0];

  wed_pkg::wed_state state;
  wed_pkg::wed_state next_state;

  logic [`WED_WORDS*`WB_DATA_W-1:0] line;  // Raw line as the beats arrive
  logic beat_hit;
  logic resp_hit;
  logic enter_req;
  logic enter_done;
  logic enter_fault;

  assign beat_hit = beat_valid && (beat_tag == MY_TAG);
  assign resp_hit = resp_valid && (resp_tag == MY_TAG);

  assign enter_req   = (state == wed_pkg::WED_IDLE) && (next_state == wed_pkg::WED_REQ);
  assign enter_done  = (state == wed_pkg::WED_WAITING) && (next_state == wed_pkg::WED_DONE);
  assign enter_fault = (state == wed_pkg::WED_WAITING) && (next_state == wed_pkg::WED_FAULTED);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= wed_pkg::WED_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      wed_pkg::WED_RESET: begin
        next_state = wed_pkg::WED_IDLE;
      end
      wed_pkg::WED_IDLE: begin
        if (enabled && !wed_valid && !wed_fault) begin  // Only one fetch per reset
          next_state = wed_pkg::WED_REQ;
        end
      end
      wed_pkg::WED_REQ: begin
        if (cmd_accept) begin
          next_state = wed_pkg::WED_WAITING;
        end
      end
      wed_pkg::WED_WAITING: begin
        if (resp_hit && (resp_code == wed_pkg::RESP_DONE)) begin
          next_state = wed_pkg::WED_DONE;
        end else if (resp_hit) begin
          next_state = wed_pkg::WED_FAULTED;
        end
      end
      wed_pkg::WED_DONE: begin
        next_state = wed_pkg::WED_IDLE;
      end
      wed_pkg::WED_FAULTED: begin
        next_state = wed_pkg::WED_IDLE;  // Sticky fault keeps it parked
      end
      default: begin
        next_state = wed_pkg::WED_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_req   <= 1'b0;
      wed_valid <= 1'b0;
      wed_fault <= 1'b0;
    end else begin
      if (enter_req) begin
        cmd_req <= 1'b1;
      end else if (cmd_accept) begin
        cmd_req <= 1'b0;  // Drops the cycle after the accept
      end
      if (enter_done) begin
        wed_valid <= 1'b1;
      end
      if (enter_fault) begin
        wed_fault <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (enter_req) begin
      cmd_address <= wed_address;  // Stable before the arbiter can grant
    end
    if ((state == wed_pkg::WED_WAITING) && beat_hit) begin
      line[beat_index*`WB_DATA_W +: `WB_DATA_W] <= beat_data;
    end
    if (enter_done) begin
      wed <= wed_pkg::map_to_wed(line);  // Visible together with wed_valid in DONE
    end
  end

  a_no_req_in_done: assert property (@(posedge clock) disable iff (!rstn)
    (state == wed_pkg::WED_DONE) |-> !cmd_req);

  a_valid_fault_excl: assert property (@(posedge clock) disable iff (!rstn)
    !(wed_valid && wed_fault));

endmodule

// File: logic/command_arbiter.sv
`timescale 1ns/100ps
`include "wed_defs.svh"

module command_arbiter (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  logic [`WED_ENGINES-1:0]                  cmd_req,
  input  logic [`WED_ENGINES-1:0][`WB_ADDR_W-1:0]  cmd_address,
  output logic [`WED_ENGINES-1:0]                  cmd_accept,
  output logic                                     cmd_valid,
  output logic [`WED_TAG_W-1:0]                    cmd_tag,
  output logic [`WB_ADDR_W-1:0]                    cmd_address_out,
  input  logic                                     cmd_ready
);

  localparam int LAST_ENGINE = `WED_ENGINES - 1;

  logic [`WED_TAG_W-1:0] rr_ptr;     // Highest priority this round
  logic [`WED_TAG_W-1:0] grant_idx;
  logic                  grant_found;
  logic                  transfer;

  // Search starts at the pointer and wraps around
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < `WED_ENGINES; k++) begin
      cand = (int'(rr_ptr) + k) % `WED_ENGINES;
      if (!grant_found && cmd_req[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand[`WED_TAG_W-1:0];
      end
    end
  end

  assign cmd_valid       = grant_found;  // Unregistered, same cycle as the request
  assign cmd_tag         = grant_idx;
  assign cmd_address_out = cmd_address[grant_idx];
  assign transfer        = cmd_valid && cmd_ready;

  always_comb begin
    cmd_accept = '0;
    if (transfer) begin
      cmd_accept[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rr_ptr <= '0;
    end else if (transfer) begin
      if (grant_idx == LAST_ENGINE[`WED_TAG_W-1:0]) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_idx + 1'b1;  // Move past the engine just served
      end
    end
  end

  a_accept_onehot: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(cmd_accept));

endmodule

// File: logic/host_read_bridge.sv
`timescale 1ns/100ps
`include "wed_defs.svh"

module host_read_bridge (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     cmd_valid,
  input  logic [`WED_TAG_W-1:0]    cmd_tag,
  input  logic [`WB_ADDR_W-1:0]    cmd_address,
  output logic                     cmd_ready,
  output logic                     beat_valid,
  output logic [`WED_TAG_W-1:0]    beat_tag,
  output logic [`WED_INDEX_W-1:0]  beat_index,
  output logic [`WB_DATA_W-1:0]    beat_data,
  output logic                     resp_valid,
  output logic [`WED_TAG_W-1:0]    resp_tag,
  output wed_pkg::response_code    resp_code,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [`WB_ADDR_W-1:0]    wb_adr,
  output logic [`WB_DATA_W/8-1:0]  wb_sel,
  input  logic [`WB_DATA_W-1:0]    wb_dat_i,
  input  logic                     wb_ack,
  input  logic                     wb_err
);

  localparam int LAST_WORD = `WED_WORDS - 1;

  wed_pkg::bridge_state state;
  wed_pkg::bridge_state next_state;

  logic [`WED_TAG_W-1:0]   tag_q;
  logic [`WB_ADDR_W-1:0]   base_q;
  logic [`WED_INDEX_W-1:0] word_cnt;
  logic [`WB_DATA_W-1:0]   data_q;
  logic                    err_flag;
  logic [`WB_ADDR_W-1:0]   word_offset;
  logic                    last_word;

  assign word_offset = {{(`WB_ADDR_W - `WED_INDEX_W - 2){1'b0}}, word_cnt, 2'b00};
  assign last_word   = (word_cnt == LAST_WORD[`WED_INDEX_W-1:0]);

  always_comb begin
    next_state = state;
    case (state)
      wed_pkg::BR_IDLE: begin
        if (cmd_valid && cmd_ready) begin
          next_state = wed_pkg::BR_CYCLE;
        end
      end
      wed_pkg::BR_CYCLE: begin
        if (wb_err) begin
          next_state = wed_pkg::BR_RESPOND;  // Line ends early, no beat
        end else if (wb_ack) begin
          next_state = wed_pkg::BR_BEAT;
        end
      end
      wed_pkg::BR_BEAT: begin
        next_state = last_word ? wed_pkg::BR_RESPOND : wed_pkg::BR_CYCLE;
      end
      wed_pkg::BR_RESPOND: begin
        next_state = wed_pkg::BR_IDLE;
      end
      default: begin
        next_state = wed_pkg::BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state     <= wed_pkg::BR_IDLE;
      cmd_ready <= 1'b0;
      word_cnt  <= '0;
      err_flag  <= 1'b0;
    end else begin
      state     <= next_state;
      cmd_ready <= (next_state == wed_pkg::BR_IDLE);  // Up one cycle after reset
      if (state == wed_pkg::BR_IDLE) begin
        word_cnt <= '0;
        err_flag <= 1'b0;
      end else if ((state == wed_pkg::BR_BEAT) && !last_word) begin
        word_cnt <= word_cnt + 1'b1;
      end
      if ((state == wed_pkg::BR_CYCLE) && wb_err) begin
        err_flag <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if ((state == wed_pkg::BR_IDLE) && cmd_valid && cmd_ready) begin
      tag_q  <= cmd_tag;
      base_q <= cmd_address;
    end
    if ((state == wed_pkg::BR_CYCLE) && wb_ack) begin
      data_q <= wb_dat_i;
    end
  end

  // Classic single-word cycle, dropped in BEAT for the gap
  assign wb_cyc = (state == wed_pkg::BR_CYCLE);
  assign wb_stb = (state == wed_pkg::BR_CYCLE);
  assign wb_we  = 1'b0;
  assign wb_adr = base_q + word_offset;
  assign wb_sel = '1;

  assign beat_valid = (state == wed_pkg::BR_BEAT);
  assign beat_tag   = tag_q;
  assign beat_index = word_cnt;
  assign beat_data  = data_q;

  assign resp_valid = (state == wed_pkg::BR_RESPOND);
  assign resp_tag   = tag_q;
  assign resp_code  = err_flag ? wed_pkg::RESP_FAULT : wed_pkg::RESP_DONE;

  a_stb_in_cyc: assert property (@(posedge clock) disable iff (!rstn)
    wb_stb |-> wb_cyc);

  // Address must hold until the slave answers
  a_adr_hold: assert property (@(posedge clock) disable iff (!rstn)
    (wb_stb && !wb_ack && !wb_err) |=> (wb_stb && $stable(wb_adr)));

endmodule

// File: logic/wed_subsystem.sv
`timescale 1ns/100ps
`include "wed_defs.svh"

module wed_subsystem (
  input  logic                                     clock,
  input  logic                                     rstn,
  input  logic [`WED_ENGINES-1:0]                  enabled,
  input  logic [`WED_ENGINES-1:0][`WB_ADDR_W-1:0]  wed_address,
  output wed_pkg::wed_t [`WED_ENGINES-1:0]         wed,
  output logic [`WED_ENGINES-1:0]                  wed_valid,
  output logic [`WED_ENGINES-1:0]                  wed_fault,
  output logic                                     wb_cyc,
  output logic                                     wb_stb,
  output logic                                     wb_we,
  output logic [`WB_ADDR_W-1:0]                    wb_adr,
  output logic [`WB_DATA_W/8-1:0]                  wb_sel,
  input  logic [`WB_DATA_W-1:0]                    wb_dat_i,
  input  logic                                     wb_ack,
  input  logic                                     wb_err
);

  logic [`WED_ENGINES-1:0]                  cmd_req;
  logic [`WED_ENGINES-1:0][`WB_ADDR_W-1:0]  cmd_address;
  logic [`WED_ENGINES-1:0]                  cmd_accept;
  logic                                     cmd_valid;
  logic [`WED_TAG_W-1:0]                    cmd_tag;
  logic [`WB_ADDR_W-1:0]                    bridge_address;
  logic                                     cmd_ready;

  // Broadcast from the bridge to every controller
  logic                    beat_valid;
  logic [`WED_TAG_W-1:0]   beat_tag;
  logic [`WED_INDEX_W-1:0] beat_index;
  logic [`WB_DATA_W-1:0]   beat_data;
  logic                    resp_valid;
  logic [`WED_TAG_W-1:0]   resp_tag;
  wed_pkg::response_code   resp_code;

  for (genvar i = 0; i < `WED_ENGINES; i++) begin : g_engine
    wed_control #(
      .ENGINE_ID(i)
    ) i_wed_control (
      .clock      (clock),
      .rstn       (rstn),
      .enabled    (enabled[i]),
      .wed_address(wed_address[i]),
      .cmd_req    (cmd_req[i]),
      .cmd_address(cmd_address[i]),
      .cmd_accept (cmd_accept[i]),
      .beat_valid (beat_valid),
      .beat_tag   (beat_tag),
      .beat_index (beat_index),
      .beat_data  (beat_data),
      .resp_valid (resp_valid),
      .resp_tag   (resp_tag),
      .resp_code  (resp_code),
      .wed        (wed[i]),
      .wed_valid  (wed_valid[i]),
      .wed_fault  (wed_fault[i])
    );
  end

  command_arbiter i_command_arbiter (
    .clock          (clock),
    .rstn           (rstn),
    .cmd_req        (cmd_req),
    .cmd_address    (cmd_address),
    .cmd_accept     (cmd_accept),
    .cmd_valid      (cmd_valid),
    .cmd_tag        (cmd_tag),
    .cmd_address_out(bridge_address),
    .cmd_ready      (cmd_ready)
  );

  host_read_bridge i_host_read_bridge (
    .clock      (clock),
    .rstn       (rstn),
    .cmd_valid  (cmd_valid),
    .cmd_tag    (cmd_tag),
    .cmd_address(bridge_address),
    .cmd_ready  (cmd_ready),
    .beat_valid (beat_valid),
    .beat_tag   (beat_tag),
    .beat_index (beat_index),
    .beat_data  (beat_data),
    .resp_valid (resp_valid),
    .resp_tag   (resp_tag),
    .resp_code  (resp_code),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err)
  );

endmodule

// File: test/wb_memory_model.sv
`timescale 1ns/100ps
`include "wed_defs.svh"

module wb_memory_model #(
  parameter int DEPTH = 256
) (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic [1:0]             wait_cycles,
  input  logic [`WB_ADDR_W-1:0]  error_address,
  input  logic                   error_enable,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic [`WB_ADDR_W-1:0]  wb_adr,
  output logic [`WB_DATA_W-1:0]  wb_dat_o,
  output logic                   wb_ack,
  output logic                   wb_err
);

  localparam int AW = $clog2(DEPTH);

  logic [`WB_DATA_W-1:0] mem [DEPTH];  // Loaded directly by the testbench
  logic [1:0]            wait_count;
  logic [AW-1:0]         word_addr;
  logic                  selected;
  logic                  respond;
  logic                  error_hit;

  assign word_addr = wb_adr[AW+1:2];
  assign selected  = wb_cyc && wb_stb;
  assign respond   = selected && (wait_count == wait_cycles);  // Wait states then answer
  assign error_hit = error_enable && (wb_adr == error_address);

  assign wb_ack   = respond && !error_hit;
  assign wb_err   = respond && error_hit;
  assign wb_dat_o = mem[word_addr];

  // Counts wait states of the current word cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wait_count <= '0;
    end else if (!selected || respond) begin
      wait_count <= '0;
    end else begin
      wait_count <= wait_count + 2'd1;
    end
  end

endmodule

// File: test/wed_tb.sv
`timescale 1ns/100ps
`include "wed_defs.svh"

module wed_tb;

  localparam logic [31:0] SEED = 32'h20fe_92d8;
  // 5 tests of up to 4 engines x 4 words x 6 cycles, plus resets and idle windows
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int ENGINE_WAIT_LIMIT = 400;

  logic                                    clock;
  logic                                    rstn;
  logic [`WED_ENGINES-1:0]                 enabled;
  logic [`WED_ENGINES-1:0][`WB_ADDR_W-1:0] wed_address;
  wed_pkg::wed_t [`WED_ENGINES-1:0]        wed;
  logic [`WED_ENGINES-1:0]                 wed_valid;
  logic [`WED_ENGINES-1:0]                 wed_fault;
  logic                                    wb_cyc;
  logic                                    wb_stb;
  logic                                    wb_we;
  logic [`WB_ADDR_W-1:0]                   wb_adr;
  logic [`WB_DATA_W/8-1:0]                 wb_sel;
  logic [`WB_DATA_W-1:0]                   wb_read_data;
  logic                                    wb_ack;
  logic                                    wb_err;
  logic [1:0]                              wait_cycles;
  logic [`WB_ADDR_W-1:0]                   error_address;
  logic                                    error_enable;

  logic [31:0] rng_state;
  logic [31:0] expected_line [`WED_ENGINES][`WED_WORDS];
  logic [31:0] line_base [`WED_ENGINES];
  int          next_word [`WED_ENGINES];
  logic        monitor_on;
  int          cycle_count;

  wed_subsystem i_wed_subsystem (
    .clock(clock), .rstn(rstn), .enabled(enabled), .wed_address(wed_address),
    .wed(wed), .wed_valid(wed_valid), .wed_fault(wed_fault),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_sel(wb_sel),
    .wb_dat_i(wb_read_data), .wb_ack(wb_ack), .wb_err(wb_err)
  );

  wb_memory_model i_wb_memory_model (
    .clock(clock), .rstn(rstn), .wait_cycles(wait_cycles),
    .error_address(error_address), .error_enable(error_enable),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_dat_o(wb_read_data), .wb_ack(wb_ack), .wb_err(wb_err)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // Each accepted word must belong to one line and come in order
  always @(posedge clock) begin : word_monitor
    int owners;
    int owner;
    int offset;
    if (rstn && wb_cyc) begin
      check_value("wb_we", 0, wb_we);
      check_value("wb_stb", 1, wb_stb);
      check_value("wb_sel", 4'hf, wb_sel);  // Full 32-bit words only
    end
    if (monitor_on && wb_cyc && wb_stb && (wb_ack || wb_err)) begin
      owners = 0;
      owner  = 0;
      for (int e = 0; e < `WED_ENGINES; e++) begin
        if (wb_adr >= line_base[e] && wb_adr < line_base[e] + 32'd16) begin
          owners++;
          owner = e;
        end
      end
      check_value("engine lines holding wb_adr", 1, owners);
      offset = int'((wb_adr - line_base[owner]) >> 2);
      check_value($sformatf("word index of wb_adr for engine %0d", owner),
                  next_word[owner], offset);
      next_word[owner] = offset + 1;
    end
  end

  task automatic wait_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic apply_reset();
    rstn    = 1'b0;
    enabled = '0;
    repeat (8) @(posedge clock);
    #2;
    rstn = 1'b1;
  endtask

  task automatic fill_background();
    for (int i = 0; i < 256; i++) begin
      i_wb_memory_model.mem[i] = {8'h5a, 8'(i), ~8'(i), 8'(i)};
    end
  endtask

  // Random line for one engine, remembered for the checks
  task automatic load_line(input int e, input logic [31:0] base);
    logic [31:0] data;
    line_base[e]   = base;
    wed_address[e] = base;
    next_word[e]   = 0;
    for (int k = 0; k < `WED_WORDS; k++) begin
      data = next_random();
      i_wb_memory_model.mem[(base >> 2) + k] = data;
      expected_line[e][k] = data;
    end
  endtask

  task automatic wait_engines(input logic [`WED_ENGINES-1:0] mask);
    int count;
    count = 0;
    while (((wed_valid | wed_fault) & mask) != mask) begin
      if (count == ENGINE_WAIT_LIMIT) begin
        $display("Engines %b never became valid or faulted", mask);
        $display("test failed");
        $fatal(1);
      end
      wait_cycle();
      count++;
    end
  endtask

  task automatic check_wed(input int e);
    wed_pkg::wed_t got;
    got = wed[e];
    check_value($sformatf("wed[%0d].source_address", e), expected_line[e][0], got.source_address);
    check_value($sformatf("wed[%0d].dest_address", e), expected_line[e][1], got.dest_address);
    check_value($sformatf("wed[%0d].length", e), expected_line[e][2], got.length);
    check_value($sformatf("wed[%0d].flags", e), expected_line[e][3], got.flags);
  endtask

  task automatic test_reset_state();
    apply_reset();
    check_value("wed_valid", 0, wed_valid);
    check_value("wed_fault", 0, wed_fault);
    repeat (10) begin
      wait_cycle();
      check_value("wb_cyc", 0, wb_cyc);
    end
  endtask

  task automatic test_single_engine();
    apply_reset();
    wait_cycles  = 2'd0;
    error_enable = 1'b0;
    load_line(2, 32'h0000_0100);
    enabled[2] = 1'b1;
    wait_engines(4'b0100);
    check_value("wed_valid", 4'b0100, wed_valid);
    check_value("wed_fault", 0, wed_fault);
    check_wed(2);
  endtask

  task automatic test_all_engines();
    apply_reset();
    wait_cycles = 2'd2;
    load_line(0, 32'h0000_0040);
    load_line(1, 32'h0000_0200);
    load_line(2, 32'h0000_00c0);
    load_line(3, 32'h0000_0380);
    monitor_on = 1'b1;
    enabled    = '1;
    wait_engines('1);
    monitor_on = 1'b0;
    check_value("wed_valid", 4'b1111, wed_valid);
    for (int e = 0; e < `WED_ENGINES; e++) begin
      check_wed(e);
      check_value($sformatf("words fetched for engine %0d", e), `WED_WORDS, next_word[e]);
    end
  endtask

  task automatic test_bus_error();
    apply_reset();
    wait_cycles = 2'd1;
    load_line(0, 32'h0000_0010);
    load_line(1, 32'h0000_0080);
    load_line(2, 32'h0000_02f0);
    load_line(3, 32'h0000_03c0);
    error_address = 32'h0000_0088;  // Word 2 of engine 1
    error_enable  = 1'b1;
    enabled       = '1;
    wait_engines('1);
    check_value("wed_fault", 4'b0010, wed_fault);
    check_value("wed_valid", 4'b1101, wed_valid);
    check_wed(0);
    check_wed(2);
    check_wed(3);
  endtask

  // Runs right after the bus error test with the enables still high
  task automatic test_fetch_once();
    wed_pkg::wed_t [`WED_ENGINES-1:0] snapshot;
    logic [`WED_ENGINES-1:0]          valid_before;
    logic [`WED_ENGINES-1:0]          fault_before;
    snapshot     = wed;
    valid_before = wed_valid;
    fault_before = wed_fault;
    repeat (50) begin
      wait_cycle();
      check_value("wb_cyc", 0, wb_cyc);
      check_value("wed_valid", valid_before, wed_valid);
      check_value("wed_fault", fault_before, wed_fault);
      for (int e = 0; e < `WED_ENGINES; e++) begin
        check_value($sformatf("wed[%0d]", e), snapshot[e], wed[e]);
      end
    end
  endtask

  initial begin
    clock         = 1'b0;
    rstn          = 1'b0;
    enabled       = '0;
    wed_address   = '0;
    wait_cycles   = 2'd0;
    error_address = '0;
    error_enable  = 1'b0;
    monitor_on    = 1'b0;
    cycle_count   = 0;
    rng_state     = SEED;
    for (int e = 0; e < `WED_ENGINES; e++) begin
      line_base[e] = 32'hffff_0000;  // Outside the memory until a test loads a line
      next_word[e] = 0;
    end
    fill_background();
    test_reset_state();
    test_single_engine();
    test_all_engines();
    test_bus_error();
    test_fetch_once();
    $display("test passed");
    $finish;
  end

endmodule

// File: all.f
+incdir+common
common/wed_pkg.sv
wed_control/wed_control.sv
logic/command_arbiter.sv
logic/host_read_bridge.sv
logic/wed_subsystem.sv
test/wb_memory_model.sv
test/wed_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench; the exit status follows the simulation result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module wed_tb -Mdir obj_dir &&
./obj_dir/Vwed_tb ||
{ echo "simulation failed or did not build"; exit 1; }
